//--- id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// --------------------
// Widths
// --------------------
`define ID_XLEN   32
`define ID_ILEN   32
`define ID_REG_AW 5

// --------------------
// Major opcodes, bits 6:0
// --------------------
`define ID_OPC_LUI    7'b0110111
`define ID_OPC_AUIPC  7'b0010111
`define ID_OPC_JAL    7'b1101111
`define ID_OPC_JALR   7'b1100111
`define ID_OPC_BRANCH 7'b1100011
`define ID_OPC_LOAD   7'b0000011
`define ID_OPC_STORE  7'b0100011
`define ID_OPC_OPIMM  7'b0010011
`define ID_OPC_OP     7'b0110011

// Trap causes, top bit marks an interrupt
`define ID_CAUSE_ILLEGAL 32'h0000_0002
`define ID_CAUSE_IRQ_EXT 32'h8000_000B

`endif

//--- id_pkg.sv
`include "id_settings.svh"

package id_pkg;

  // --------------------
  // Plain vector types
  // --------------------
  // Raw or expanded instruction word
  typedef logic [`ID_ILEN-1:0]   instr_t;
  // PC, immediate or data word
  typedef logic [`ID_XLEN-1:0]   xlen_t;
  // Architectural register index
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;
  // Trap cause, interrupt flag in the top bit
  typedef logic [`ID_XLEN-1:0]   cause_t;

  // Functional unit that executes the instruction
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_BRANCH = 3'd2,
    FU_LOAD   = 3'd3,
    FU_STORE  = 3'd4
  } fu_t;

  // --------------------
  // Bundles
  // --------------------
  // Exception or interrupt attached to an instruction
  typedef struct packed {
    logic   valid;
    cause_t cause;
  } exception_t;

  // One entry handed over by fetch
  typedef struct packed {
    instr_t     instr;
    xlen_t      pc;
    exception_t ex;
  } fetch_entry_t;

  // Compact scoreboard entry handed to issue
  typedef struct packed {
    xlen_t      pc;
    fu_t        fu;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    xlen_t      imm;
    // Set when the entry came from a 16-bit encoding
    logic       is_compressed;
    exception_t ex;
  } sb_entry_t;

endpackage

//--- rvc_expander.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module rvc_expander import id_pkg::*; (
  input  instr_t instr_i,
  output instr_t instr_o,
  output logic   is_compressed_o,
  output logic   illegal_o
);

  // Lower half holds the 16-bit encoding
  logic [15:0] cinstr;

  assign cinstr          = instr_i[15:0];
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    // Unsupported codes keep the raw word and raise the illegal flag
    instr_o   = instr_i;
    illegal_o = 1'b0;

    unique case (cinstr[1:0])
      // --------------------
      // Quadrant 0
      // --------------------
      2'b00: begin
        unique case (cinstr[15:13])
          // C.LW expands to lw rd', uimm(rs1')
          3'b010: instr_o = {5'b0, cinstr[5], cinstr[12:10], cinstr[6], 2'b00,
                             2'b01, cinstr[9:7], 3'b010, 2'b01, cinstr[4:2],
                             `ID_OPC_LOAD};
          // C.SW expands to sw rs2', uimm(rs1')
          3'b110: instr_o = {5'b0, cinstr[5], cinstr[12], 2'b01, cinstr[4:2],
                             2'b01, cinstr[9:7], 3'b010, cinstr[11:10], cinstr[6],
                             2'b00, `ID_OPC_STORE};
          default: illegal_o = 1'b1;
        endcase
      end

      // --------------------
      // Quadrant 1
      // --------------------
      2'b01: begin
        unique case (cinstr[15:13])
          // C.ADDI expands to addi rd, rd, nzimm
          3'b000: instr_o = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2], cinstr[11:7],
                             3'b000, cinstr[11:7], `ID_OPC_OPIMM};
          // C.LI expands to addi rd, x0, imm
          3'b010: instr_o = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2], 5'b0,
                             3'b000, cinstr[11:7], `ID_OPC_OPIMM};
          // C.J becomes jal x0 with the offset bits rearranged into J format
          3'b101: instr_o = {cinstr[12], cinstr[8], cinstr[10:9], cinstr[6], cinstr[7],
                             cinstr[2], cinstr[11], cinstr[5:3], cinstr[12],
                             {8{cinstr[12]}}, 5'b0, `ID_OPC_JAL};
          // C.BEQZ and C.BNEZ share one form where bit 13 picks beq or bne
          3'b110,
          3'b111: instr_o = {cinstr[12], {3{cinstr[12]}}, cinstr[6:5], cinstr[2], 5'b0,
                             2'b01, cinstr[9:7], 2'b00, cinstr[13], cinstr[11:10],
                             cinstr[4:3], cinstr[12], `ID_OPC_BRANCH};
          default: illegal_o = 1'b1;
        endcase
      end

      // --------------------
      // Quadrant 2
      // --------------------
      2'b10: begin
        // Only C.MV and C.ADD, since rs2 of zero means C.JR or C.JALR
        if (cinstr[15:13] == 3'b100 && cinstr[6:2] != 5'b0) begin
          if (cinstr[12]) begin
            // C.ADD expands to add rd, rd, rs2
            instr_o = {7'b0, cinstr[6:2], cinstr[11:7], 3'b000, cinstr[11:7], `ID_OPC_OP};
          end else begin
            // C.MV expands to add rd, x0, rs2
            instr_o = {7'b0, cinstr[6:2], 5'b0, 3'b000, cinstr[11:7], `ID_OPC_OP};
          end
        end else begin
          illegal_o = 1'b1;
        end
      end

      // Full 32-bit word passes unchanged
      default: instr_o = instr_i;
    endcase
  end

  // A compressed word lands on a 32-bit opcode unless flagged illegal
  expand_check: assert final (
    is_compressed_o ? (illegal_o || instr_o[1:0] == 2'b11)
                    : (!illegal_o && instr_o == instr_i)
  );

endmodule

//--- instr_decoder.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module instr_decoder import id_pkg::*; (
  input  instr_t    instr_i,
  input  logic      is_compressed_i,
  input  logic      rvc_illegal_i,
  input  xlen_t     pc_i,
  output sb_entry_t entry_o,
  output logic      is_ctrl_flow_o
);

  // --------------------
  // Immediate formats
  // --------------------
  xlen_t imm_i_type;
  xlen_t imm_s_type;
  xlen_t imm_b_type;
  xlen_t imm_u_type;
  xlen_t imm_j_type;
  logic  illegal_opc;

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.fu            = FU_NONE;
    entry_o.is_compressed = is_compressed_i;
    is_ctrl_flow_o        = 1'b0;
    illegal_opc           = 1'b0;

    unique case (instr_i[6:0])
      // Upper immediates write rd only
      `ID_OPC_LUI, `ID_OPC_AUIPC: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_u_type;
      end
      `ID_OPC_JAL: begin
        entry_o.fu     = FU_BRANCH;
        entry_o.rd     = instr_i[11:7];
        entry_o.imm    = imm_j_type;
        is_ctrl_flow_o = 1'b1;
      end
      `ID_OPC_JALR: begin
        entry_o.fu     = FU_BRANCH;
        entry_o.rs1    = instr_i[19:15];
        entry_o.rd     = instr_i[11:7];
        entry_o.imm    = imm_i_type;
        is_ctrl_flow_o = 1'b1;
      end
      // Conditional branch, no destination
      `ID_OPC_BRANCH: begin
        entry_o.fu     = FU_BRANCH;
        entry_o.rs1    = instr_i[19:15];
        entry_o.rs2    = instr_i[24:20];
        entry_o.imm    = imm_b_type;
        is_ctrl_flow_o = 1'b1;
      end
      `ID_OPC_LOAD: begin
        entry_o.fu  = FU_LOAD;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_i_type;
      end
      `ID_OPC_STORE: begin
        entry_o.fu  = FU_STORE;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_s_type;
      end
      `ID_OPC_OPIMM: begin
        entry_o.fu  = FU_ALU;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_i_type;
      end
      // Register-register ALU op, no immediate
      `ID_OPC_OP: begin
        entry_o.fu  = FU_ALU;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.rd  = instr_i[11:7];
      end
      default: illegal_opc = 1'b1;
    endcase

    // Illegal words go nowhere but still carry their exception to issue
    if (illegal_opc || rvc_illegal_i) begin
      entry_o.fu       = FU_NONE;
      entry_o.ex.valid = 1'b1;
      entry_o.ex.cause = `ID_CAUSE_ILLEGAL;
      is_ctrl_flow_o   = 1'b0;
    end
  end

endmodule

//--- trap_select.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module trap_select import id_pkg::*; (
  input  logic       irq_i,
  input  logic       irq_en_i,
  input  exception_t fetch_ex_i,
  output exception_t trap_o
);

  // Interrupt only taken when globally enabled
  logic irq_pending;

  assign irq_pending = irq_i && irq_en_i;

  always_comb begin
    // Nothing to report by default
    trap_o = '0;

    if (irq_pending) begin
      // Interrupt replaces the instruction, fetch fault is dropped
      trap_o.valid = 1'b1;
      trap_o.cause = `ID_CAUSE_IRQ_EXT;
    end else if (fetch_ex_i.valid) begin
      // Fetch fault passes with its own cause
      trap_o = fetch_ex_i;
    end
  end

  // An enabled interrupt must never be lost behind a fetch fault
  irq_taken_check: assert final (!(irq_i && irq_en_i) || trap_o.valid);

endmodule

//--- issue_register.sv
`timescale 1ns/10ps

module issue_register import id_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  logic       fetch_valid_i,
  input  logic       issue_ack_i,
  input  sb_entry_t  decoded_i,
  input  exception_t trap_i,
  input  logic       ctrl_flow_i,
  input  instr_t     orig_instr_i,
  output logic       fetch_ready_o,
  output logic       issue_valid_o,
  output sb_entry_t  issue_entry_o,
  output instr_t     orig_instr_o,
  output logic       is_ctrl_flow_o
);

  // Everything stored alongside the valid bit
  typedef struct packed {
    sb_entry_t entry;
    instr_t    orig_instr;
    logic      ctrl_flow;
  } issue_payload_t;

  issue_payload_t payload_d, payload_q;
  logic           valid_d, valid_q;
  logic           accept;

  // Space now, or space freed by this cycle's acknowledge
  assign fetch_ready_o = !valid_q || issue_ack_i;
  assign accept        = fetch_valid_i && fetch_ready_o;

  // --------------------
  // Next entry
  // --------------------
  always_comb begin
    payload_d.entry      = decoded_i;
    payload_d.orig_instr = orig_instr_i;
    payload_d.ctrl_flow  = ctrl_flow_i;
    // Interrupt or fetch fault outranks the decoder's illegal flag
    if (trap_i.valid) begin
      payload_d.entry.ex = trap_i;
    end
  end

  always_comb begin
    valid_d = valid_q;
    // Acknowledge empties the slot
    if (issue_ack_i) begin
      valid_d = 1'b0;
    end
    if (accept) begin
      valid_d = 1'b1;
    end
    // Flush wins over a same-cycle accept
    if (flush_i) begin
      valid_d = 1'b0;
    end
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      payload_q <= payload_d;
    end
  end

  assign issue_valid_o  = valid_q;
  assign issue_entry_o  = payload_q.entry;
  assign orig_instr_o   = payload_q.orig_instr;
  assign is_ctrl_flow_o = payload_q.ctrl_flow;

  // Entry waiting on issue may only leave by acknowledge or flush
  hold_under_backpressure: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_o && !issue_ack_i && !flush_i) |=> issue_valid_o
  );

endmodule

//--- id_stage.sv
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  fetch_entry_t fetch_entry_i,
  input  logic         fetch_valid_i,
  output logic         fetch_ready_o,
  input  logic         issue_ack_i,
  input  logic         irq_i,
  input  logic         irq_en_i,
  output sb_entry_t    issue_entry_o,
  output logic         issue_valid_o,
  output instr_t       orig_instr_o,
  output logic         is_ctrl_flow_o
);

  instr_t     expanded_instr;
  logic       is_compressed;
  logic       rvc_illegal;
  sb_entry_t  decoded_entry;
  logic       ctrl_flow;
  exception_t trap;

  // --------------------
  // Decode path
  // --------------------
  rvc_expander rvc_expander_i (
    .instr_i         (fetch_entry_i.instr),
    .instr_o         (expanded_instr),
    .is_compressed_o (is_compressed),
    .illegal_o       (rvc_illegal)
  );

  instr_decoder instr_decoder_i (
    .instr_i         (expanded_instr),
    .is_compressed_i (is_compressed),
    .rvc_illegal_i   (rvc_illegal),
    .pc_i            (fetch_entry_i.pc),
    .entry_o         (decoded_entry),
    .is_ctrl_flow_o  (ctrl_flow)
  );

  // Trap decision runs beside the decoder
  trap_select trap_select_i (
    .irq_i      (irq_i),
    .irq_en_i   (irq_en_i),
    .fetch_ex_i (fetch_entry_i.ex),
    .trap_o     (trap)
  );

  // --------------------
  // ID/issue register
  // --------------------
  issue_register issue_register_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .issue_ack_i    (issue_ack_i),
    .decoded_i      (decoded_entry),
    .trap_i         (trap),
    .ctrl_flow_i    (ctrl_flow),
    // Raw word, not the expanded form
    .orig_instr_i   (fetch_entry_i.instr),
    .fetch_ready_o  (fetch_ready_o),
    .issue_valid_o  (issue_valid_o),
    .issue_entry_o  (issue_entry_o),
    .orig_instr_o   (orig_instr_o),
    .is_ctrl_flow_o (is_ctrl_flow_o)
  );

endmodule

//--- tb_id_stage.sv
`timescale 1ns/10ps
`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

  // One line of the data file, stimulus then expected result
  typedef struct packed {
    instr_t     instr;
    xlen_t      pc;
    logic       fex_valid;
    cause_t     fex_cause;
    logic       irq;
    logic       irq_en;
    logic [2:0] fu;
    reg_addr_t  rd;
    xlen_t      imm;
    logic       comp;
    logic       ex_valid;
    cause_t     ex_cause;
    logic       ctrl;
  } vector_t;

  localparam int TIMEOUT_CYCLES = 100;

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  fetch_entry_t fetch_entry_i;
  logic         fetch_valid_i;
  logic         fetch_ready_o;
  logic         issue_ack_i;
  logic         irq_i;
  logic         irq_en_i;
  sb_entry_t    issue_entry_o;
  logic         issue_valid_o;
  instr_t       orig_instr_o;
  logic         is_ctrl_flow_o;

  vector_t vectors[$];
  string   names[$];

  id_stage dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_entry_i  (fetch_entry_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .issue_ack_i    (issue_ack_i),
    .irq_i          (irq_i),
    .irq_en_i       (irq_en_i),
    .issue_entry_o  (issue_entry_o),
    .issue_valid_o  (issue_valid_o),
    .orig_instr_o   (orig_instr_o),
    .is_ctrl_flow_o (is_ctrl_flow_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [`ID_XLEN-1:0] expected,
                             input logic [`ID_XLEN-1:0] actual);
    assert (actual === expected) else begin
      $display("ERROR: %s %s expected %h actual %h", test, field, expected, actual);
      abort_run();
    end
  endtask

  // Whole issue side against one line of the file
  task automatic check_issue(input int idx);
    vector_t v;
    string   t;
    v = vectors[idx];
    t = names[idx];
    check_value(t, "issue_valid_o", 1, issue_valid_o);
    check_value(t, "pc", v.pc, issue_entry_o.pc);
    check_value(t, "fu", v.fu, issue_entry_o.fu);
    check_value(t, "rd", v.rd, issue_entry_o.rd);
    check_value(t, "imm", v.imm, issue_entry_o.imm);
    check_value(t, "is_compressed", v.comp, issue_entry_o.is_compressed);
    check_value(t, "ex.valid", v.ex_valid, issue_entry_o.ex.valid);
    check_value(t, "ex.cause", v.ex_cause, issue_entry_o.ex.cause);
    check_value(t, "is_ctrl_flow_o", v.ctrl, is_ctrl_flow_o);
    // Raw word, never the expanded one
    check_value(t, "orig_instr_o", v.instr, orig_instr_o);
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    string       line;
    string       name;
    logic [31:0] f [13];
    vector_t     v;
    fd = $fopen("id_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open id_testdata.txt for reading");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      // Skip blank and comment lines
      if (line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                       f[10], f[11], f[12]);
        if (code != 14) begin
          $display("Malformed line in id_testdata.txt: %s", line);
          abort_run();
        end
        v.instr     = f[0];
        v.pc        = f[1];
        v.fex_valid = f[2][0];
        v.fex_cause = f[3];
        v.irq       = f[4][0];
        v.irq_en    = f[5][0];
        v.fu        = f[6][2:0];
        v.rd        = f[7][4:0];
        v.imm       = f[8];
        v.comp      = f[9][0];
        v.ex_valid  = f[10][0];
        v.ex_cause  = f[11];
        v.ctrl      = f[12][0];
        vectors.push_back(v);
        names.push_back(name);
      end
    end
    $fclose(fd);
    if (vectors.size() < 2) begin
      $display("id_testdata.txt holds too few test vectors");
      abort_run();
    end
  endtask

  task automatic drive_vector(input int idx);
    fetch_entry_i.instr    = vectors[idx].instr;
    fetch_entry_i.pc       = vectors[idx].pc;
    fetch_entry_i.ex.valid = vectors[idx].fex_valid;
    fetch_entry_i.ex.cause = vectors[idx].fex_cause;
    irq_i                  = vectors[idx].irq;
    irq_en_i               = vectors[idx].irq_en;
    fetch_valid_i          = 1'b1;
  endtask

  task automatic release_inputs();
    fetch_entry_i = '0;
    fetch_valid_i = 1'b0;
    irq_i         = 1'b0;
    irq_en_i      = 1'b0;
  endtask

  // Sampling happens on the falling edge, away from the drive point
  task automatic wait_ready(input string test);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: fetch_ready_o stayed low for %0d cycles in %s", cycles, test);
        abort_run();
      end
      @(negedge clk_i);
    end
  endtask

  task automatic wait_issue_valid(input string test, output int cycles);
    cycles = 0;
    @(negedge clk_i);
    while (!issue_valid_o) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: issue_valid_o stayed low for %0d cycles in %s", cycles, test);
        abort_run();
      end
      @(negedge clk_i);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int idle;
    int latency;
    int last;
    void'($urandom(32'hd56d55f8));
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    issue_ack_i   = 1'b0;
    release_inputs();
    load_vectors();
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("reset", "issue_valid_o", 0, issue_valid_o);
    check_value("reset", "fetch_ready_o", 1, fetch_ready_o);

    // One entry at a time, acknowledge withheld for a random while
    foreach (vectors[i]) begin
      @(posedge clk_i);
      #1 drive_vector(i);
      wait_ready(names[i]);
      @(posedge clk_i);
      #1 release_inputs();
      wait_issue_valid(names[i], latency);
      check_value(names[i], "issue latency", 0, latency);
      check_issue(i);
      idle = $urandom % 4;
      repeat (idle) begin
        @(negedge clk_i);
        check_value(names[i], "fetch_ready_o", 0, fetch_ready_o);
        check_issue(i);
      end
      @(posedge clk_i);
      #1 issue_ack_i = 1'b1;
      @(negedge clk_i);
      check_value(names[i], "fetch_ready_o", 1, fetch_ready_o);
      @(posedge clk_i);
      #1 issue_ack_i = 1'b0;
      @(negedge clk_i);
      check_value(names[i], "issue_valid_o", 0, issue_valid_o);
    end

    // Back-to-back, one entry per cycle
    foreach (vectors[i]) begin
      @(posedge clk_i);
      #1 drive_vector(i);
      issue_ack_i = (i > 0);
      @(negedge clk_i);
      check_value(names[i], "fetch_ready_o", 1, fetch_ready_o);
      if (i > 0) begin
        check_issue(i - 1);
      end
    end
    last = vectors.size() - 1;
    @(posedge clk_i);
    #1 release_inputs();
    issue_ack_i = 1'b1;
    @(negedge clk_i);
    check_issue(last);
    @(posedge clk_i);
    #1 issue_ack_i = 1'b0;
    @(negedge clk_i);
    check_value(names[last], "issue_valid_o", 0, issue_valid_o);

    // Flush alone, then flush racing an ack plus a new entry
    for (int k = 0; k < 2; k++) begin
      @(posedge clk_i);
      #1 drive_vector(0);
      wait_ready("flush");
      @(posedge clk_i);
      #1 drive_vector(1);
      issue_ack_i = (k == 1);
      flush_i     = 1'b1;
      @(negedge clk_i);
      check_issue(0);
      @(posedge clk_i);
      #1 release_inputs();
      issue_ack_i = 1'b0;
      flush_i     = 1'b0;
      // Neither entry may surface afterwards
      repeat (3) begin
        @(negedge clk_i);
        check_value("flush", "issue_valid_o", 0, issue_valid_o);
        check_value("flush", "fetch_ready_o", 1, fetch_ready_o);
      end
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
id_pkg.sv
rvc_expander.sv
instr_decoder.sv
trap_select.sv
issue_register.sv
id_stage.sv
tb_id_stage.sv

//--- id_testdata.txt
# name instr pc fex_valid fex_cause irq irq_en | fu rd imm is_compressed ex_valid ex_cause ctrl
# all numbers hex; fu codes 0 none, 1 alu, 2 branch, 3 load, 4 store
add_reg     002081b3 80000000 0 00000000 0 0 1 03 00000000 0 0 00000000 0
addi_neg    ffd30293 80000004 0 00000000 0 0 1 05 fffffffd 0 0 00000000 0
lui_upper   123453b7 80000008 0 00000000 0 0 1 07 12345000 0 0 00000000 0
lw_base     00c4a403 8000000c 0 00000000 0 0 3 08 0000000c 0 0 00000000 0
sw_base     00a5a423 80000010 0 00000000 0 0 4 00 00000008 0 0 00000000 0
beq_fwd     00208863 80000014 0 00000000 0 0 2 00 00000010 0 0 00000000 1
c_addi      000012f5 80000018 0 00000000 0 0 1 05 fffffffd 1 0 00000000 0
c_lw        000044c0 8000001a 0 00000000 0 0 3 08 0000000c 1 0 00000000 0
c_j         0000a801 8000001c 0 00000000 0 0 2 00 00000010 1 0 00000000 1
c_bnez      0000e481 8000001e 0 00000000 0 0 2 00 00000008 1 0 00000000 1
illegal_opc 0000007f 80000020 0 00000000 0 0 0 00 00000000 0 1 00000002 0
illegal_rvc 00000000 80000024 0 00000000 0 0 0 00 00000000 1 1 00000002 0
irq_illegal 0000007f 80000028 0 00000000 1 1 0 00 00000000 0 1 8000000b 0
fetch_fault 0000007f 8000002c 1 00000001 0 0 0 00 00000000 0 1 00000001 0
irq_masked  002081b3 80000030 0 00000000 1 0 1 03 00000000 0 0 00000000 0
